//--- hw/cache.sv
module cache #(
	parameter int INDEX_BITS = 3
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  mem_req,
	input  logic                  mem_write,
	input  cache_pkg::addr_t      mem_address,
	input  cache_pkg::byte_mask_t mem_byte_enable256,
	input  cache_pkg::line_t      mem_wdata256,
	output logic                  mem_ack,
	output cache_pkg::line_t      mem_rdata256,
	output logic                  pmem_req,
	output logic                  pmem_write,
	output cache_pkg::addr_t      pmem_address,
	output cache_pkg::line_t      pmem_wdata,
	input  logic                  pmem_ack,
	input  cache_pkg::line_t      pmem_rdata
);

	logic [1:0]            load_data;
	logic [1:0]            load_tag;
	logic [1:0]            set_valid;
	logic                  clear_valid;
	logic [1:0]            set_dirty;
	logic [1:0]            clear_dirty;
	logic                  load_lru;
	logic                  fill_sel;
	logic [INDEX_BITS-1:0] flush_index;
	logic                  use_flush;
	logic                  wb_sel;
	logic                  hold_address;
	logic                  hit;
	logic                  hit_way;
	logic                  victim_way;
	logic                  victim_dirty;

	cache_control #(.INDEX_BITS(INDEX_BITS)) control (
		.clk          (clk),
		.reset        (reset),
		.mem_req      (mem_req),
		.mem_write    (mem_write),
		.pmem_ack     (pmem_ack),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.mem_ack      (mem_ack),
		.pmem_req     (pmem_req),
		.pmem_write   (pmem_write),
		.load_data    (load_data),
		.load_tag     (load_tag),
		.set_valid    (set_valid),
		.clear_valid  (clear_valid),
		.set_dirty    (set_dirty),
		.clear_dirty  (clear_dirty),
		.load_lru     (load_lru),
		.fill_sel     (fill_sel),
		.flush_index  (flush_index),
		.use_flush    (use_flush),
		.wb_sel       (wb_sel),
		.hold_address (hold_address)
	);

	cache_dp #(.INDEX_BITS(INDEX_BITS)) datapath (
		.clk                (clk),
		.reset              (reset),
		.mem_address        (mem_address),
		.mem_wdata256       (mem_wdata256),
		.mem_byte_enable256 (mem_byte_enable256),
		.pmem_rdata         (pmem_rdata),
		.load_data          (load_data),
		.load_tag           (load_tag),
		.set_valid          (set_valid),
		.clear_valid        (clear_valid),
		.set_dirty          (set_dirty),
		.clear_dirty        (clear_dirty),
		.load_lru           (load_lru),
		.fill_sel           (fill_sel),
		.flush_index        (flush_index),
		.use_flush          (use_flush),
		.wb_sel             (wb_sel),
		.hold_address       (hold_address),
		.mem_rdata256       (mem_rdata256),
		.pmem_wdata         (pmem_wdata),
		.pmem_address       (pmem_address),
		.hit                (hit),
		.hit_way            (hit_way),
		.victim_way         (victim_way),
		.victim_dirty       (victim_dirty)
	);

endmodule

//--- hw/cache_array.sv
module cache_array #(
	parameter int WIDTH      = 1,
	parameter int INDEX_BITS = 3
) (
	input  logic                  clk,
	input  logic                  load,
	input  logic [INDEX_BITS-1:0] index,
	input  logic [WIDTH-1:0]      datain,
	output logic [WIDTH-1:0]      dataout
);

	// One entry per set
	logic [WIDTH-1:0] entries [2**INDEX_BITS];

	// Read is combinational at the current index
	assign dataout = entries[index];

	always_ff @(posedge clk) begin
		if (load) begin
			entries[index] <= datain;
		end
	end

endmodule

//--- hw/cache_control.sv
module cache_control #(
	parameter int INDEX_BITS = 3
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  mem_req,
	input  logic                  mem_write,
	input  logic                  pmem_ack,
	input  logic                  hit,
	input  logic                  hit_way,
	input  logic                  victim_way,
	input  logic                  victim_dirty,
	output logic                  mem_ack,
	output logic                  pmem_req,
	output logic                  pmem_write,
	output logic [1:0]            load_data,
	output logic [1:0]            load_tag,
	output logic [1:0]            set_valid,
	output logic                  clear_valid,
	output logic [1:0]            set_dirty,
	output logic [1:0]            clear_dirty,
	output logic                  load_lru,
	output logic                  fill_sel,
	output logic [INDEX_BITS-1:0] flush_index,
	output logic                  use_flush,
	output logic                  wb_sel,
	output logic                  hold_address
);
	import cache_pkg::*;

	cache_state_t          state;
	cache_state_t          next_state;
	logic [INDEX_BITS-1:0] flush_count;
	logic                  ack_seen;
	logic                  ack_rise;
	logic                  ack_done;

	// Memory handshake phases
	assign ack_rise = pmem_ack && !ack_seen;
	assign ack_done = ack_seen && !pmem_ack;

	assign flush_index = flush_count;

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= FLUSH;
			flush_count <= '0;
			ack_seen    <= 1'b0;
		end else begin
			state <= next_state;
			if (state == FLUSH) begin
				flush_count <= flush_count + 1'b1;
			end
			if (ack_rise && (state == WRITEBACK || state == FILL)) begin
				ack_seen <= 1'b1;
			end else if (ack_done) begin
				ack_seen <= 1'b0;
			end
		end
	end

	// ==============================
	// Next state and strobes
	// ==============================

	always_comb begin
		next_state   = state;
		mem_ack      = 1'b0;
		pmem_req     = 1'b0;
		pmem_write   = 1'b0;
		load_data    = 2'b00;
		load_tag     = 2'b00;
		set_valid    = 2'b00;
		clear_valid  = 1'b0;
		set_dirty    = 2'b00;
		clear_dirty  = 2'b00;
		load_lru     = 1'b0;
		fill_sel     = 1'b0;
		use_flush    = 1'b0;
		wb_sel       = 1'b0;
		hold_address = 1'b0;

		unique case (state)
			FLUSH: begin
				use_flush   = 1'b1;
				clear_valid = 1'b1;
				if (&flush_count) begin
					next_state = IDLE;
				end
			end
			IDLE: begin
				hold_address = mem_req;
				if (mem_req) begin
					next_state = LOOKUP;
				end
			end
			LOOKUP: begin
				if (hit) begin
					next_state = RESPOND;
				end else if (victim_dirty) begin
					next_state = WRITEBACK;
				end else begin
					next_state = FILL;
				end
			end
			WRITEBACK: begin
				pmem_req   = !ack_seen;
				pmem_write = 1'b1;
				wb_sel     = 1'b1;
				if (ack_done) begin
					next_state = FILL;
				end
			end
			FILL: begin
				pmem_req = !ack_seen;
				fill_sel = 1'b1;
				// Fetched line is captured once, on the first ack cycle
				if (ack_rise) begin
					load_data[victim_way]   = 1'b1;
					load_tag[victim_way]    = 1'b1;
					set_valid[victim_way]   = 1'b1;
					clear_dirty[victim_way] = 1'b1;
				end
				if (ack_done) begin
					next_state = RESPOND;
				end
			end
			RESPOND: begin
				mem_ack  = 1'b1;
				load_lru = 1'b1;
				if (mem_write) begin
					load_data[hit_way] = 1'b1;
					set_dirty[hit_way] = 1'b1;
				end
				next_state = RELEASE;
			end
			RELEASE: begin
				mem_ack = 1'b1;
				if (!mem_req) begin
					next_state = IDLE;
				end
			end
			default: begin
				next_state = FLUSH;
			end
		endcase
	end

endmodule

//--- hw/cache_dp.sv
module cache_dp #(
	parameter int INDEX_BITS = 3
) (
	input  logic                  clk,
	input  logic                  reset,
	input  cache_pkg::addr_t      mem_address,
	input  cache_pkg::line_t      mem_wdata256,
	input  cache_pkg::byte_mask_t mem_byte_enable256,
	input  cache_pkg::line_t      pmem_rdata,
	input  logic [1:0]            load_data,
	input  logic [1:0]            load_tag,
	input  logic [1:0]            set_valid,
	input  logic                  clear_valid,
	input  logic [1:0]            set_dirty,
	input  logic [1:0]            clear_dirty,
	input  logic                  load_lru,
	input  logic                  fill_sel,
	input  logic [INDEX_BITS-1:0] flush_index,
	input  logic                  use_flush,
	input  logic                  wb_sel,
	input  logic                  hold_address,
	output cache_pkg::line_t      mem_rdata256,
	output cache_pkg::line_t      pmem_wdata,
	output cache_pkg::addr_t      pmem_address,
	output logic                  hit,
	output logic                  hit_way,
	output logic                  victim_way,
	output logic                  victim_dirty
);
	import cache_pkg::*;

	localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

	typedef logic [TAG_BITS-1:0]   tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;

	addr_t  addr_q;
	index_t req_index;
	index_t index;
	tag_t   req_tag;

	line_t  way_data  [2];
	tag_t   way_tag   [2];
	logic   way_valid [2];
	logic   way_dirty [2];
	logic   way_hit   [2];
	logic   lru;
	line_t  merged_line;
	line_t  line_in;

	// Request address, held for the whole access
	always_ff @(posedge clk) begin
		if (reset) begin
			addr_q <= '0;
		end else if (hold_address) begin
			addr_q <= mem_address;
		end
	end

	assign req_index = addr_q[OFFSET_BITS +: INDEX_BITS];
	assign req_tag   = addr_q[31 -: TAG_BITS];
	assign index     = use_flush ? flush_index : req_index;

	// ==============================
	// Storage for both ways
	// ==============================

	for (genvar w = 0; w < 2; w++) begin : g_way
		cache_array #(.WIDTH($bits(line_t)), .INDEX_BITS(INDEX_BITS)) data_array (
			.clk     (clk),
			.load    (load_data[w]),
			.index   (index),
			.datain  (line_in),
			.dataout (way_data[w])
		);

		cache_array #(.WIDTH(TAG_BITS), .INDEX_BITS(INDEX_BITS)) tag_array (
			.clk     (clk),
			.load    (load_tag[w]),
			.index   (index),
			.datain  (req_tag),
			.dataout (way_tag[w])
		);

		// Flush writes zero, a fill writes one
		cache_array #(.WIDTH(1), .INDEX_BITS(INDEX_BITS)) valid_array (
			.clk     (clk),
			.load    (set_valid[w] | clear_valid),
			.index   (index),
			.datain  (!clear_valid),
			.dataout (way_valid[w])
		);

		cache_array #(.WIDTH(1), .INDEX_BITS(INDEX_BITS)) dirty_array (
			.clk     (clk),
			.load    (set_dirty[w] | clear_dirty[w]),
			.index   (index),
			.datain  (set_dirty[w]),
			.dataout (way_dirty[w])
		);

		assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
	end

	// LRU bit names the way to evict next
	cache_array #(.WIDTH(1), .INDEX_BITS(INDEX_BITS)) lru_array (
		.clk     (clk),
		.load    (load_lru),
		.index   (index),
		.datain  (!hit_way),
		.dataout (lru)
	);

	// ==============================
	// Lookup and line source
	// ==============================

	assign hit     = way_hit[0] || way_hit[1];
	assign hit_way = way_hit[1];

	// Empty ways are taken before the LRU bit is consulted
	assign victim_way   = !way_valid[0] ? 1'b0 : (!way_valid[1] ? 1'b1 : lru);
	assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

	// After a fill the stored line is already the fetched one
	always_comb begin
		merged_line = way_data[hit_way];
		for (int b = 0; b < $bits(byte_mask_t); b++) begin
			if (mem_byte_enable256[b]) begin
				merged_line[8*b +: 8] = mem_wdata256[8*b +: 8];
			end
		end
	end

	assign line_in      = fill_sel ? pmem_rdata : merged_line;
	assign mem_rdata256 = way_data[hit_way];
	assign pmem_wdata   = way_data[victim_way];
	assign pmem_address = {wb_sel ? way_tag[victim_way] : req_tag, req_index,
		{OFFSET_BITS{1'b0}}};

endmodule

//--- hw/cache_pkg.sv
package cache_pkg;

	// ==============================
	// Widths
	// ==============================

	// Byte offset within a 256-bit line
	localparam int OFFSET_BITS = 5;

	typedef logic [31:0]  addr_t;
	typedef logic [255:0] line_t;
	typedef logic [31:0]  byte_mask_t;

	// ==============================
	// Controller states
	// ==============================

	typedef enum logic [2:0] {
		FLUSH,
		IDLE,
		LOOKUP,
		WRITEBACK,
		FILL,
		RESPOND,
		RELEASE
	} cache_state_t;

endpackage

//--- sim.f
hw/cache_pkg.sv
hw/cache_array.sv
hw/cache_dp.sv
hw/cache_control.sv
hw/cache.sv
verification/cache_props.sv
verification/cache_tb.sv

//--- verification/cache_input.txt
# op address mask write_line expected_line (hex, lines most significant word first)
# expected_line is zero for writes, mask bit n selects byte n of the line
R 00000040 00000000 0000000000000000000000000000000000000000000000000000000000000000 0000004000000040000000400000004000000040000000400000004000000040
R 00000040 00000000 0000000000000000000000000000000000000000000000000000000000000000 0000004000000040000000400000004000000040000000400000004000000040
W 00000040 0000000f aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 0000000000000000000000000000000000000000000000000000000000000000
R 00000040 00000000 0000000000000000000000000000000000000000000000000000000000000000 00000040000000400000004000000040000000400000004000000040aaaaaaaa
R 00000140 00000000 0000000000000000000000000000000000000000000000000000000000000000 0000014000000140000001400000014000000140000001400000014000000140
R 00000040 00000000 0000000000000000000000000000000000000000000000000000000000000000 00000040000000400000004000000040000000400000004000000040aaaaaaaa
W 00000240 f0000000 cccccccccccccccccccccccccccccccccccccccccccccccccccccccccccccccc 0000000000000000000000000000000000000000000000000000000000000000
R 00000040 00000000 0000000000000000000000000000000000000000000000000000000000000000 00000040000000400000004000000040000000400000004000000040aaaaaaaa
R 00000140 00000000 0000000000000000000000000000000000000000000000000000000000000000 0000014000000140000001400000014000000140000001400000014000000140
R 00000240 00000000 0000000000000000000000000000000000000000000000000000000000000000 cccccccc00000240000002400000024000000240000002400000024000000240
R 00000040 00000000 0000000000000000000000000000000000000000000000000000000000000000 00000040000000400000004000000040000000400000004000000040aaaaaaaa
R 00000064 00000000 0000000000000000000000000000000000000000000000000000000000000000 0000006000000060000000600000006000000060000000600000006000000060
W 00000060 00000003 1234567812345678123456781234567812345678123456781234567812345678 0000000000000000000000000000000000000000000000000000000000000000
R 00000060 00000000 0000000000000000000000000000000000000000000000000000000000000000 0000006000000060000000600000006000000060000000600000006000005678
W 000010a0 0000ff00 7777777766666666555555554444444433333333222222221111111100000000 0000000000000000000000000000000000000000000000000000000000000000
R 000010a0 00000000 0000000000000000000000000000000000000000000000000000000000000000 000010a0000010a0000010a0000010a03333333322222222000010a0000010a0
W 000010a0 80000001 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000000
R 000010a0 00000000 0000000000000000000000000000000000000000000000000000000000000000 ff0010a0000010a0000010a0000010a03333333322222222000010a0000010ff
R 000000a0 00000000 0000000000000000000000000000000000000000000000000000000000000000 000000a0000000a0000000a0000000a0000000a0000000a0000000a0000000a0
R 000011a0 00000000 0000000000000000000000000000000000000000000000000000000000000000 000011a0000011a0000011a0000011a0000011a0000011a0000011a0000011a0

//--- verification/cache_props.sv
module cache_props (
	input logic             clk,
	input logic             reset,
	input logic             mem_req,
	input logic             mem_ack,
	input logic             pmem_req,
	input logic             pmem_ack,
	input logic             pmem_write,
	input cache_pkg::addr_t pmem_address
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	// Both handshakes idle once reset has been seen
	reset_idle: assert property (@(posedge clk) reset |=> (!mem_ack && !pmem_req))
		else begin
			$error("mem_ack or pmem_req high in the cycle after reset");
			failures++;
		end

	// Requester side holds ack until req is dropped
	ack_held: assert property (@(posedge clk) disable iff (reset)
		(mem_ack && mem_req) |=> mem_ack)
		else begin
			$error("mem_ack fell while mem_req was still high");
			failures++;
		end

	// ==============================
	// Memory side
	// ==============================

	req_held: assert property (@(posedge clk) disable iff (reset)
		(pmem_req && !pmem_ack) |=> pmem_req)
		else begin
			$error("pmem_req fell before pmem_ack was raised");
			failures++;
		end

	req_stable: assert property (@(posedge clk) disable iff (reset)
		(pmem_req && $past(pmem_req)) |-> ($stable(pmem_address) && $stable(pmem_write)))
		else begin
			$error("pmem_address or pmem_write changed while pmem_req was high");
			failures++;
		end

endmodule

bind cache cache_props props (
	.clk          (clk),
	.reset        (reset),
	.mem_req      (mem_req),
	.mem_ack      (mem_ack),
	.pmem_req     (pmem_req),
	.pmem_ack     (pmem_ack),
	.pmem_write   (pmem_write),
	.pmem_address (pmem_address)
);

//--- verification/cache_tb.sv
module cache_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import cache_pkg::*;

	localparam int INDEX_BITS = 3;
	localparam int SETS       = 2**INDEX_BITS;
	localparam int CLK_PERIOD = 10;
	localparam INPUT_FILE     = "verification/cache_input.txt";

	logic       clk = 1'b0;
	logic       reset;
	logic       mem_req;
	logic       mem_write;
	addr_t      mem_address;
	byte_mask_t mem_byte_enable256;
	line_t      mem_wdata256;
	logic       mem_ack;
	line_t      mem_rdata256;
	logic       pmem_req;
	logic       pmem_write;
	addr_t      pmem_address;
	line_t      pmem_wdata;
	logic       pmem_ack;
	line_t      pmem_rdata;

	// Accesses from the data file
	logic [7:0] acc_op    [$];
	addr_t      acc_addr  [$];
	byte_mask_t acc_mask  [$];
	line_t      acc_wdata [$];
	line_t      acc_exp   [$];

	line_t       pmem    [addr_t];
	line_t       ref_mem [addr_t];
	logic [31:0] model_tag   [SETS][2];
	bit          model_valid [SETS][2];
	bit          model_dirty [SETS][2];
	bit          model_lru   [SETS];
	int          pmem_reads;
	int          pmem_writes;
	logic [31:0] lfsr;

	cache #(.INDEX_BITS(INDEX_BITS)) cache_i (
		.clk                (clk),
		.reset              (reset),
		.mem_req            (mem_req),
		.mem_write          (mem_write),
		.mem_address        (mem_address),
		.mem_byte_enable256 (mem_byte_enable256),
		.mem_wdata256       (mem_wdata256),
		.mem_ack            (mem_ack),
		.mem_rdata256       (mem_rdata256),
		.pmem_req           (pmem_req),
		.pmem_write         (pmem_write),
		.pmem_address       (pmem_address),
		.pmem_wdata         (pmem_wdata),
		.pmem_ack           (pmem_ack),
		.pmem_rdata         (pmem_rdata)
	);

	initial begin
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// ==============================
	// Helpers and reference model
	// ==============================

	task automatic compare_values(input string name, input line_t expected, input line_t actual);
		if (expected !== actual) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic line_t initial_line(input addr_t line_addr);
		return {8{line_addr}};
	endfunction

	function automatic line_t ref_line(input addr_t line_addr);
		return ref_mem.exists(line_addr) ? ref_mem[line_addr] : initial_line(line_addr);
	endfunction

	function automatic line_t merge_bytes(input line_t old_line, input line_t data,
		input byte_mask_t mask);
		line_t result;
		result = old_line;
		for (int b = 0; b < 32; b++) begin
			if (mask[b]) begin
				result[8*b +: 8] = data[8*b +: 8];
			end
		end
		return result;
	endfunction

	// Two-way LRU model of the memory traffic one access should cause
	function automatic void model_access(input addr_t addr, input logic write,
		output int fills, output int writebacks);
		int          set;
		int          way;
		logic [31:0] tag;
		set        = addr[OFFSET_BITS +: INDEX_BITS];
		tag        = addr >> (OFFSET_BITS + INDEX_BITS);
		fills      = 0;
		writebacks = 0;
		if (model_valid[set][0] && model_tag[set][0] == tag) begin
			way = 0;
		end else if (model_valid[set][1] && model_tag[set][1] == tag) begin
			way = 1;
		end else begin
			if (!model_valid[set][0]) begin
				way = 0;
			end else if (!model_valid[set][1]) begin
				way = 1;
			end else begin
				way = model_lru[set];
			end
			writebacks = (model_valid[set][way] && model_dirty[set][way]) ? 1 : 0;
			fills      = 1;
			model_valid[set][way] = 1'b1;
			model_tag[set][way]   = tag;
			model_dirty[set][way] = 1'b0;
		end
		if (write) begin
			model_dirty[set][way] = 1'b1;
		end
		model_lru[set] = (way == 0);
	endfunction

	task automatic load_accesses();
		int          fd;
		int          count;
		logic [63:0] token;
		string       rest;
		addr_t       addr;
		byte_mask_t  mask;
		line_t       wdata;
		line_t       expected;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			$display("ERROR: cannot open %s", INPUT_FILE);
			$display("Simulation failed");
			$fatal(1, "missing data file");
		end else begin
			while ($fscanf(fd, "%s", token) == 1) begin
				if (token == "#") begin
					count = $fgets(rest, fd);
				end else begin
					count = $fscanf(fd, "%h %h %h %h", addr, mask, wdata, expected);
					if ((token != "R" && token != "W") || count != 4) begin
						$display("ERROR: malformed line starting with %s in %s", token,
							INPUT_FILE);
						$display("Simulation failed");
						$fatal(1, "bad data file");
					end
					acc_op.push_back(token[7:0]);
					acc_addr.push_back(addr);
					acc_mask.push_back(mask);
					acc_wdata.push_back(wdata);
					acc_exp.push_back(expected);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic watchdog();
		int limit;
		limit = acc_op.size() * 200 + SETS + 4;
		#(limit * CLK_PERIOD);
		$display("ERROR: the cache stopped answering within %0d cycles", limit);
		$display("Simulation failed");
		$fatal(1, "timeout");
	endtask

	// A failed handshake or reset assertion ends the run
	initial begin
		wait (cache_i.props.failures != 0);
		$display("ERROR: an assertion on the handshakes or the reset state failed");
		$display("Simulation failed");
		$fatal(1, "assertion failure");
	end

	// ==============================
	// Requester driver
	// ==============================

	task automatic run_access(input int n);
		string name;
		int    fills_exp;
		int    wb_exp;
		int    reads_start;
		int    writes_start;
		addr_t line_addr;
		name      = $sformatf("access %0d", n + 1);
		line_addr = {acc_addr[n][31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		model_access(acc_addr[n], acc_op[n] == "W", fills_exp, wb_exp);
		reads_start        = pmem_reads;
		writes_start       = pmem_writes;
		mem_req            = 1'b1;
		mem_write          = (acc_op[n] == "W");
		mem_address        = acc_addr[n];
		mem_byte_enable256 = acc_mask[n];
		mem_wdata256       = acc_wdata[n];
		do begin
			@(negedge clk);
		end while (!mem_ack);
		if (!mem_write) begin
			compare_values({name, " read data"}, acc_exp[n], mem_rdata256);
			compare_values({name, " model data"}, ref_line(line_addr), mem_rdata256);
		end
		compare_values({name, " fills"}, fills_exp, pmem_reads - reads_start);
		compare_values({name, " write-backs"}, wb_exp, pmem_writes - writes_start);
		mem_req = 1'b0;
		do begin
			@(negedge clk);
		end while (mem_ack);
		if (mem_write) begin
			ref_mem[line_addr] = merge_bytes(ref_line(line_addr), acc_wdata[n], acc_mask[n]);
		end
	endtask

	// Memory answers each request after 0 to 7 cycles
	initial begin
		int    delay;
		addr_t line_addr;
		pmem_ack   = 1'b0;
		pmem_rdata = '0;
		lfsr       = 32'h3101;
		forever begin
			@(negedge clk);
			if (pmem_req) begin
				delay = 0;
				for (int i = 0; i < 3; i++) begin
					delay = (delay << 1) | lfsr[0];
					lfsr  = lfsr_step(lfsr);
				end
				repeat (delay) @(negedge clk);
				line_addr = pmem_address;
				compare_values("memory address alignment", '0, line_addr[OFFSET_BITS-1:0]);
				if (pmem_write) begin
					compare_values($sformatf("write-back to %h", line_addr),
						ref_line(line_addr), pmem_wdata);
					pmem[line_addr] = pmem_wdata;
					pmem_writes++;
				end else begin
					pmem_rdata = pmem.exists(line_addr) ? pmem[line_addr] :
						initial_line(line_addr);
					pmem_reads++;
				end
				pmem_ack = 1'b1;
				do begin
					@(negedge clk);
				end while (pmem_req);
				pmem_ack = 1'b0;
			end
		end
	end

	initial begin
		reset              = 1'b1;
		mem_req            = 1'b0;
		mem_write          = 1'b0;
		mem_address        = '0;
		mem_byte_enable256 = '0;
		mem_wdata256       = '0;
		pmem_reads         = 0;
		pmem_writes        = 0;
		load_accesses();
		fork
			watchdog();
		join_none
		repeat (4) @(negedge clk);
		reset = 1'b0;
		// Both handshakes stay quiet during the flush walk
		repeat (SETS) begin
			@(negedge clk);
			compare_values("flush mem_ack", '0, mem_ack);
			compare_values("flush pmem_req", '0, pmem_req);
		end
		for (int n = 0; n < acc_op.size(); n++) begin
			run_access(n);
		end
		if (cache_i.props.failures == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "%0d assertions failed", cache_i.props.failures);
		end
	end

endmodule
